// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

  // Base integer width, RV32 only
  localparam int XLEN = 32;

  // Architectural data types
  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_idx_t;

  // First fetch address after reset
  localparam addr_t RESET_PC = 32'h0000_0000;

  // ----------------------------------------------------------
  // Major opcodes, bits [6:0]
  // ----------------------------------------------------------
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // Only SYSTEM encoding the core accepts
  localparam instr_t INSTR_EBREAK = 32'h0010_0073;

  // Load/store widths, bit 2 marks unsigned loads
  localparam logic [2:0] F3_BYTE  = 3'b000;
  localparam logic [2:0] F3_HALF  = 3'b001;
  localparam logic [2:0] F3_WORD  = 3'b010;
  localparam logic [2:0] F3_BYTEU = 3'b100;
  localparam logic [2:0] F3_HALFU = 3'b101;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // ALU funct3, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

endpackage

// File: design/rv_uarch_pkg.sv
package rv_uarch_pkg;

  // ----------------------------------------------------------
  // Datapath selectors
  // ----------------------------------------------------------

  // ALU operation
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // First ALU operand
  typedef enum logic [1:0] {
    A_RS1,
    A_PC,
    A_ZERO
  } alu_a_sel_t;

  // Write-back source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } res_sel_t;

  // ----------------------------------------------------------
  // Decoded instruction, consumed by every later stage
  // ----------------------------------------------------------
  typedef struct packed {
    alu_op_t              alu_op;
    alu_a_sel_t           alu_a_sel;
    logic                 alu_b_imm;
    res_sel_t             res_sel;
    logic                 reg_write;
    rv_isa_pkg::reg_idx_t rd;
    logic                 mem_read;
    logic                 mem_write;
    logic [2:0]           mem_funct3;
    logic                 is_branch;
    logic [2:0]           branch_funct3;
    logic                 is_jal;
    logic                 is_jalr;
    logic                 is_ebreak;
    logic                 illegal;
    rv_isa_pkg::word_t    imm;
  } ctrl_t;

  // One data-memory write, taken at the rising edge
  typedef struct packed {
    logic              we;
    rv_isa_pkg::addr_t addr;
    rv_isa_pkg::word_t data;
    logic [3:0]        strb;
  } dmem_wr_t;

endpackage

// File: design/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                dmem_stall,
  input  rv_uarch_pkg::ctrl_t ctrl,
  input  logic                branch_taken,
  input  rv_isa_pkg::addr_t   jump_target,
  input  logic                mem_misaligned,
  output rv_isa_pkg::addr_t   pc,
  output logic                imem_ren,
  output logic                retire,
  output logic                ebreak,
  output logic                trap
);
  import rv_isa_pkg::*;

  logic  halt;
  logic  advance;
  logic  taken;
  logic  target_bad;
  logic  trap_now;
  addr_t pc_next;

  // Halt is simply either sticky flag
  assign halt     = ebreak || trap;
  assign imem_ren = !halt;

  // Core moves forward only when running and not stalled
  assign advance = !halt && !dmem_stall;

  // ----------------------------------------------------------
  // Next PC and trap causes
  // ----------------------------------------------------------
  assign taken      = branch_taken || ctrl.is_jal || ctrl.is_jalr;
  assign pc_next    = taken ? jump_target : pc + 32'd4;
  // No compressed set, so targets must be word aligned
  assign target_bad = taken && (jump_target[1:0] != 2'b00);
  assign trap_now   = ctrl.illegal || mem_misaligned || target_bad;

  // Commit permit; a halting instruction writes nothing
  assign retire = advance && !trap_now && !ctrl.is_ebreak;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= RESET_PC;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      if (retire) begin
        pc <= pc_next;
      end
      // Flags rise one cycle after the halting instruction, then stick
      if (advance && ctrl.is_ebreak) begin
        ebreak <= 1'b1;
      end
      if (advance && trap_now) begin
        trap <= 1'b1;
      end
    end
  end

  // Targets come from execute, so alignment relies on the trap check here
  assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::word_t    wdata,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data
);
  import rv_isa_pkg::*;

  // x1..x31, x0 has no storage
  word_t regs [1:31];

  // Write at retirement, x0 writes dropped
  always_ff @(posedge clk) begin
    if (we && (rd != 5'd0)) begin
      regs[rd] <= wdata;
    end
  end

  // Asynchronous reads, x0 reads as zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  // Enable is built from fetch and decode outputs
  assert property (@(posedge clk) disable iff (!rst_n) we |-> !$isunknown(rd))
    else $error("register write with unknown index");

endmodule

// File: design/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_isa_pkg::instr_t   instr,
  input  rv_isa_pkg::word_t    rs1_data,
  input  rv_isa_pkg::word_t    rs2_data,
  output rv_isa_pkg::reg_idx_t rs1,
  output rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t    rs1_val,
  output rv_isa_pkg::word_t    rs2_val,
  output rv_uarch_pkg::ctrl_t  ctrl
);
  import rv_isa_pkg::*;
  import rv_uarch_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  logic       use_rs1;
  logic       use_rs2;

  // Funct3 to ALU op; alt selects SUB or SRA
  function automatic alu_op_t alu_from_f3(logic [2:0] f3, logic alt);
    case (f3)
      F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Fields and immediates
  // ----------------------------------------------------------
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ----------------------------------------------------------
  // Control decode
  // ----------------------------------------------------------
  always_comb begin
    ctrl               = '0;
    ctrl.alu_op        = ALU_ADD;
    ctrl.alu_a_sel     = A_RS1;
    ctrl.res_sel       = RES_ALU;
    ctrl.rd            = instr[11:7];
    ctrl.mem_funct3    = funct3;
    ctrl.branch_funct3 = funct3;
    use_rs1            = 1'b0;
    use_rs2            = 1'b0;

    case (opcode)
      OP_LUI: begin
        ctrl.alu_a_sel = A_ZERO;
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.alu_a_sel = A_PC;
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      OP_JAL: begin
        ctrl.is_jal    = 1'b1;
        ctrl.imm       = imm_j;
        ctrl.res_sel   = RES_PC4;
        ctrl.reg_write = 1'b1;
      end
      OP_JALR: begin
        ctrl.is_jalr   = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.res_sel   = RES_PC4;
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = (funct3 != 3'b000);
        use_rs1        = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.imm       = imm_b;
        // 010 and 011 are unassigned
        ctrl.illegal   = (funct3[2:1] == 2'b01);
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
      end
      OP_LOAD: begin
        ctrl.mem_read  = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.res_sel   = RES_MEM;
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = !(funct3 inside {F3_BYTE, F3_HALF, F3_WORD, F3_BYTEU, F3_HALFU});
        use_rs1        = 1'b1;
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_s;
        ctrl.illegal   = !(funct3 inside {F3_BYTE, F3_HALF, F3_WORD});
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
      end
      OP_IMM: begin
        // SUB has no immediate form, only SRAI uses the alt bit
        ctrl.alu_op    = alu_from_f3(funct3, funct7[5] && (funct3 == F3_SR));
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.reg_write = 1'b1;
        if (funct3 == F3_SLL) begin
          ctrl.illegal = (funct7 != 7'b0000000);
        end else if (funct3 == F3_SR) begin
          ctrl.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
        use_rs1 = 1'b1;
      end
      OP_REG: begin
        ctrl.alu_op    = alu_from_f3(funct3, funct7[5]);
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = !((funct7 == 7'b0000000) ||
                           ((funct7 == 7'b0100000) && (funct3 inside {F3_ADD, F3_SR})));
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
      end
      OP_SYSTEM: begin
        // ECALL and CSR forms are not implemented
        ctrl.is_ebreak = (instr == INSTR_EBREAK);
        ctrl.illegal   = (instr != INSTR_EBREAK);
      end
      default: begin
        ctrl.illegal = 1'b1;
      end
    endcase

    // An illegal word must leave no architectural trace
    if (ctrl.illegal) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_write = 1'b0;
    end
  end

  // Operands the instruction does not read are held at zero
  assign rs1_val = use_rs1 ? rs1_data : '0;
  assign rs2_val = use_rs2 ? rs2_data : '0;

endmodule

// File: design/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  rv_uarch_pkg::ctrl_t ctrl,
  input  rv_isa_pkg::addr_t   pc,
  input  rv_isa_pkg::word_t   rs1_data,
  input  rv_isa_pkg::word_t   rs2_data,
  output rv_isa_pkg::word_t   alu_result,
  output logic                branch_taken,
  output rv_isa_pkg::addr_t   jump_target
);
  import rv_isa_pkg::*;
  import rv_uarch_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;
  logic       cond;

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------
  always_comb begin
    case (ctrl.alu_a_sel)
      A_RS1:   op_a = rs1_data;
      A_PC:    op_a = pc;
      default: op_a = '0;
    endcase
  end

  assign op_b  = ctrl.alu_b_imm ? ctrl.imm : rs2_data;
  // Shift amount is the low five bits of either operand source
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << shamt;
      ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> shamt;
      ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      default:  alu_result = op_b;
    endcase
  end

  // ----------------------------------------------------------
  // Branch compare and target
  // ----------------------------------------------------------
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.branch_funct3)
      F3_BEQ:  cond = eq;
      F3_BNE:  cond = !eq;
      F3_BLT:  cond = lt;
      F3_BGE:  cond = !lt;
      F3_BLTU: cond = ltu;
      F3_BGEU: cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = ctrl.is_branch && cond;

  // JALR clears bit 0, all others are PC relative
  assign jump_target = ctrl.is_jalr ? ((rs1_data + ctrl.imm) & ~32'd1) : pc + ctrl.imm;

endmodule

// File: design/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
  input  rv_uarch_pkg::ctrl_t    ctrl,
  input  rv_isa_pkg::word_t      alu_result,
  input  rv_isa_pkg::word_t      rs2_data,
  input  rv_isa_pkg::addr_t      pc,
  input  logic                   retire,
  input  rv_isa_pkg::word_t      dmem_rdata,
  output logic                   dmem_ren,
  output rv_isa_pkg::addr_t      dmem_raddr,
  output rv_uarch_pkg::dmem_wr_t dmem_wr,
  output logic                   mem_misaligned,
  output rv_isa_pkg::word_t      rd_data
);
  import rv_isa_pkg::*;
  import rv_uarch_pkg::*;

  addr_t      word_addr;
  logic [1:0] off;
  word_t      lane;
  word_t      load_data;

  // Memory sees word addresses, the low bits pick the lane
  assign word_addr = {alu_result[XLEN-1:2], 2'b00};
  assign off       = alu_result[1:0];

  // Half needs even, word needs a multiple of 4
  assign mem_misaligned = (ctrl.mem_read || ctrl.mem_write) &&
                          (((ctrl.mem_funct3[1:0] == F3_HALF[1:0]) && off[0]) ||
                           ((ctrl.mem_funct3[1:0] == F3_WORD[1:0]) && (off != 2'b00)));

  // ----------------------------------------------------------
  // Store path
  // ----------------------------------------------------------
  // A misaligned store traps in fetch, so retire stays low for it
  always_comb begin
    dmem_wr.we   = ctrl.mem_write && retire;
    dmem_wr.addr = word_addr;
    case (ctrl.mem_funct3)
      F3_BYTE: begin
        dmem_wr.data = {4{rs2_data[7:0]}};
        dmem_wr.strb = 4'b0001 << off;
      end
      F3_HALF: begin
        dmem_wr.data = {2{rs2_data[15:0]}};
        dmem_wr.strb = 4'b0011 << {off[1], 1'b0};
      end
      default: begin
        dmem_wr.data = rs2_data;
        dmem_wr.strb = 4'b1111;
      end
    endcase
  end

  // ----------------------------------------------------------
  // Load path
  // ----------------------------------------------------------
  assign dmem_ren   = ctrl.mem_read && retire;
  assign dmem_raddr = word_addr;

  // Bring the addressed lane down to bit 0
  assign lane = dmem_rdata >> {off, 3'b000};

  always_comb begin
    case (ctrl.mem_funct3)
      F3_BYTE:  load_data = {{24{lane[7]}}, lane[7:0]};
      F3_BYTEU: load_data = {24'b0, lane[7:0]};
      F3_HALF:  load_data = {{16{lane[15]}}, lane[15:0]};
      F3_HALFU: load_data = {16'b0, lane[15:0]};
      default:  load_data = dmem_rdata;
    endcase
  end

  // Write-back source
  always_comb begin
    case (ctrl.res_sel)
      RES_MEM: rd_data = load_data;
      RES_PC4: rd_data = pc + 32'd4;
      default: rd_data = alu_result;
    endcase
  end

  // Write enable comes from fetch, the strobe from the access width
  always_comb begin
    if (dmem_wr.we) begin
      assert (dmem_wr.strb != 4'b0000)
        else $error("store with empty strobe");
    end
  end

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                   clk,
  input  logic                   rst_n,
  // Instruction memory, same-cycle read
  output logic                   imem_ren,
  output rv_isa_pkg::addr_t      imem_raddr,
  input  rv_isa_pkg::instr_t     imem_rdata,
  // Data memory read, same-cycle
  output logic                   dmem_ren,
  output rv_isa_pkg::addr_t      dmem_raddr,
  input  rv_isa_pkg::word_t      dmem_rdata,
  // Data memory write, taken at the edge
  output rv_uarch_pkg::dmem_wr_t dmem_wr,
  input  logic                   dmem_stall,
  // Sticky halt status
  output logic                   ebreak,
  output logic                   trap
);
  import rv_isa_pkg::*;
  import rv_uarch_pkg::*;

  addr_t    pc;
  ctrl_t    ctrl;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    alu_result;
  word_t    rd_data;
  addr_t    jump_target;
  logic     branch_taken;
  logic     mem_misaligned;
  logic     retire;

  assign imem_raddr = pc;

  // ----------------------------------------------------------
  // Stages
  // ----------------------------------------------------------
  rv_fetch u_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .dmem_stall     (dmem_stall),
    .ctrl           (ctrl),
    .branch_taken   (branch_taken),
    .jump_target    (jump_target),
    .mem_misaligned (mem_misaligned),
    .pc             (pc),
    .imem_ren       (imem_ren),
    .retire         (retire),
    .ebreak         (ebreak),
    .trap           (trap)
  );

  rv_decode u_decode (
    .instr    (imem_rdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .ctrl     (ctrl)
  );

  // Write port commits with the instruction
  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .we       (retire && ctrl.reg_write && !ctrl.illegal),
    .rd       (ctrl.rd),
    .wdata    (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .ctrl         (ctrl),
    .pc           (pc),
    .rs1_data     (rs1_val),
    .rs2_data     (rs2_val),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .jump_target  (jump_target)
  );

  rv_lsu u_lsu (
    .ctrl           (ctrl),
    .alu_result     (alu_result),
    .rs2_data       (rs2_val),
    .pc             (pc),
    .retire         (retire),
    .dmem_rdata     (dmem_rdata),
    .dmem_ren       (dmem_ren),
    .dmem_raddr     (dmem_raddr),
    .dmem_wr        (dmem_wr),
    .mem_misaligned (mem_misaligned),
    .rd_data        (rd_data)
  );

endmodule

// File: dv/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
  import rv_isa_pkg::*;
  import rv_uarch_pkg::*;

  localparam int NUM_TESTS    = 6;
  localparam int PROG_WORDS   = 12;
  localparam int MEM_WORDS    = 64;
  localparam int RESULT_IDX   = 'h40 / 4;
  localparam int RESET_CYCLES = 4;
  localparam int HALT_HOLD    = 20;
  // 50 cycles per program word, plus reset and the post-halt window
  localparam int WATCHDOG_CYCLES =
    NUM_TESTS * (PROG_WORDS * 50 + RESET_CYCLES + HALT_HOLD + 4);

  logic     clk        = 1'b0;
  logic     rst_n      = 1'b0;
  logic     dmem_stall = 1'b0;
  logic     imem_ren;
  addr_t    imem_raddr;
  instr_t   imem_rdata;
  logic     dmem_ren;
  addr_t    dmem_raddr;
  word_t    dmem_rdata;
  dmem_wr_t dmem_wr;
  logic     ebreak;
  logic     trap;

  // Memory models, reloaded before every test
  instr_t imem [MEM_WORDS];
  word_t  dmem [MEM_WORDS];
  logic   load_mem = 1'b0;
  int     cur_test = 0;

  // Stall generator state
  logic        stall_en = 1'b0;
  logic [31:0] rng      = 32'd74;

  // Program table, one row per test
  string  test_name  [NUM_TESTS];
  instr_t prog       [NUM_TESTS][PROG_WORDS];
  int     prog_len   [NUM_TESTS];
  word_t  exp_mem    [NUM_TESTS];
  logic   exp_ebreak [NUM_TESTS];
  logic   exp_trap   [NUM_TESTS];
  logic   stall_on   [NUM_TESTS];

  rv_core dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_wr    (dmem_wr),
    .dmem_stall (dmem_stall),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Instruction encoders
  // ------------------------------------------------------------
  function automatic instr_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic instr_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  // Branch offset in bytes, bit 0 dropped
  function automatic instr_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic instr_t u_type(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic instr_t j_type(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // Opcode 0 is illegal, so a runaway fetch traps
  function automatic instr_t stray_word(int idx);
    logic [24:0] addr;
    addr = 25'(idx) << 2;
    return {addr, 7'b0000000};
  endfunction

  // Data image, every word tagged with its byte address
  function automatic word_t fill_word(int idx);
    logic [15:0] addr;
    addr = 16'(idx) << 2;
    return {16'h5A00, addr};
  endfunction

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ------------------------------------------------------------
  // Memory models and stall generator
  // ------------------------------------------------------------
  assign imem_rdata = imem[imem_raddr[7:2]];
  assign dmem_rdata = dmem[dmem_raddr[7:2]];

  // Single writer for both memories, loads win over stores
  always @(posedge clk) begin
    if (load_mem) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        if (i < PROG_WORDS) begin
          imem[i] <= prog[cur_test][i];
        end else begin
          imem[i] <= stray_word(i);
        end
        dmem[i] <= fill_word(i);
      end
    end else if (dmem_wr.we) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wr.strb[b]) begin
          dmem[dmem_wr.addr[7:2]][b*8 +: 8] <= dmem_wr.data[b*8 +: 8];
        end
      end
    end
  end

  // Roughly one stalled cycle in four
  always @(posedge clk) begin
    rng = xorshift(rng);
    dmem_stall <= stall_en && (rng[1:0] == 2'b00);
  end

  // ------------------------------------------------------------
  // Checks, table and test sequence
  // ------------------------------------------------------------
  task automatic check(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "check failed");
    end
  endtask

  task automatic new_row(int r, string name, word_t mem40, logic eb, logic tr, logic st);
    test_name[r]  = name;
    exp_mem[r]    = mem40;
    exp_ebreak[r] = eb;
    exp_trap[r]   = tr;
    stall_on[r]   = st;
    prog_len[r]   = 0;
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[r][i] = stray_word(i);
    end
  endtask

  task automatic put_instr(int r, instr_t w);
    prog[r][prog_len[r]] = w;
    prog_len[r] = prog_len[r] + 1;
  endtask

  task automatic build_table();
    // -7 and 3 give SUB 10, SRA -1, SLTU 1; x7 ends at 0xEDCBAF60
    new_row(0, "alu", 32'hEDCB_AF60, 1'b1, 1'b0, 1'b1);
    put_instr(0, i_type(12'hFF9, 5'd0, F3_ADD, 5'd1, OP_IMM));
    put_instr(0, i_type(12'h003, 5'd0, F3_ADD, 5'd2, OP_IMM));
    put_instr(0, r_type(7'h20, 5'd1, 5'd2, F3_ADD, 5'd3));
    put_instr(0, r_type(7'h20, 5'd2, 5'd1, F3_SR, 5'd4));
    put_instr(0, r_type(7'h00, 5'd1, 5'd2, F3_SLTU, 5'd5));
    put_instr(0, i_type(12'h004, 5'd3, F3_SLL, 5'd6, OP_IMM));
    put_instr(0, r_type(7'h00, 5'd6, 5'd4, F3_XOR, 5'd7));   // 0xFFFFFF5F
    put_instr(0, r_type(7'h00, 5'd5, 5'd7, F3_ADD, 5'd7));   // 0xFFFFFF60
    put_instr(0, u_type(20'h12345, 5'd8, OP_LUI));
    put_instr(0, r_type(7'h00, 5'd8, 5'd7, F3_XOR, 5'd7));
    put_instr(0, s_type(12'h040, 5'd7, 5'd0, F3_WORD));
    put_instr(0, INSTR_EBREAK);
    // SH 0xF80D to the upper half, loads read it back, SB 0xF5 to lane 1
    new_row(1, "load_store", 32'hF80D_F540, 1'b1, 1'b0, 1'b1);
    put_instr(1, i_type(12'h040, 5'd0, F3_ADD, 5'd1, OP_IMM));
    put_instr(1, i_type(12'h80D, 5'd0, F3_ADD, 5'd2, OP_IMM));
    put_instr(1, s_type(12'h002, 5'd2, 5'd1, F3_HALF));
    put_instr(1, i_type(12'h003, 5'd1, F3_BYTE, 5'd3, OP_LOAD));   // 0xFFFFFFF8
    put_instr(1, i_type(12'h002, 5'd1, F3_BYTEU, 5'd4, OP_LOAD));  // 0x0000000D
    put_instr(1, i_type(12'h002, 5'd1, F3_HALF, 5'd5, OP_LOAD));   // 0xFFFFF80D
    put_instr(1, i_type(12'h002, 5'd1, F3_HALFU, 5'd6, OP_LOAD));  // 0x0000F80D
    put_instr(1, r_type(7'h20, 5'd5, 5'd6, F3_ADD, 5'd7));         // 0x00010000
    put_instr(1, r_type(7'h00, 5'd3, 5'd7, F3_ADD, 5'd7));         // 0x0000FFF8
    put_instr(1, r_type(7'h00, 5'd4, 5'd7, F3_XOR, 5'd7));         // 0x0000FFF5
    put_instr(1, s_type(12'h001, 5'd7, 5'd1, F3_BYTE));
    put_instr(1, INSTR_EBREAK);
    // Link of the JAL at 0x10 is 0x14, the callee sets x7 to 0x300
    // The word skipped by BNE is illegal, so a fall-through traps
    new_row(2, "control_flow", 32'h0000_0314, 1'b1, 1'b0, 1'b1);
    put_instr(2, i_type(12'h001, 5'd0, F3_ADD, 5'd1, OP_IMM));
    put_instr(2, b_type(13'h008, 5'd0, 5'd1, F3_BNE));
    put_instr(2, 32'hFFFF_FFFF);
    put_instr(2, b_type(13'h010, 5'd0, 5'd1, F3_BEQ));
    put_instr(2, j_type(21'h010, 5'd5));
    put_instr(2, r_type(7'h00, 5'd5, 5'd7, F3_ADD, 5'd7));
    put_instr(2, s_type(12'h040, 5'd7, 5'd0, F3_WORD));
    put_instr(2, INSTR_EBREAK);
    put_instr(2, i_type(12'h300, 5'd0, F3_ADD, 5'd7, OP_IMM));
    put_instr(2, i_type(12'h000, 5'd5, 3'b000, 5'd0, OP_JALR));
    // Only the store before the illegal word lands
    new_row(3, "illegal", 32'h0000_0055, 1'b0, 1'b1, 1'b1);
    put_instr(3, i_type(12'h055, 5'd0, F3_ADD, 5'd1, OP_IMM));
    put_instr(3, s_type(12'h040, 5'd1, 5'd0, F3_WORD));
    put_instr(3, 32'hFFFF_FFFF);
    put_instr(3, i_type(12'h066, 5'd0, F3_ADD, 5'd1, OP_IMM));
    put_instr(3, s_type(12'h040, 5'd1, 5'd0, F3_WORD));
    put_instr(3, INSTR_EBREAK);
    // Word store to 0x42 traps, 0x40 keeps its fill value
    new_row(4, "misaligned", fill_word(RESULT_IDX), 1'b0, 1'b1, 1'b1);
    put_instr(4, i_type(12'h042, 5'd0, F3_ADD, 5'd1, OP_IMM));
    put_instr(4, i_type(12'h077, 5'd0, F3_ADD, 5'd2, OP_IMM));
    put_instr(4, s_type(12'h000, 5'd2, 5'd1, F3_WORD));
    put_instr(4, s_type(12'h040, 5'd2, 5'd0, F3_WORD));
    put_instr(4, INSTR_EBREAK);
    // ALU program again without stalls, same image expected
    new_row(5, "stall_halt", 32'hEDCB_AF60, 1'b1, 1'b0, 1'b0);
    for (int i = 0; i < prog_len[0]; i++) begin
      put_instr(5, prog[0][i]);
    end
  endtask

  task automatic run_test(int t);
    // Load memories while the core sits in reset
    @(posedge clk);
    rst_n    <= 1'b0;
    stall_en <= 1'b0;
    load_mem <= 1'b1;
    cur_test <= t;
    @(posedge clk);
    load_mem <= 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    rst_n    <= 1'b1;
    stall_en <= stall_on[t];
    // Outputs sampled mid-cycle
    @(negedge clk);
    while (!(ebreak || trap)) begin
      @(negedge clk);
    end
    $display("%0t: %s halted", $time, test_name[t]);
    // Halted core must stay quiet
    repeat (HALT_HOLD) begin
      @(negedge clk);
      check({test_name[t], " store after halt"}, 32'd0, {31'd0, dmem_wr.we});
      check({test_name[t], " load after halt"}, 32'd0, {31'd0, dmem_ren});
      check({test_name[t], " fetch after halt"}, 32'd0, {31'd0, imem_ren});
    end
    check({test_name[t], " word 0x40"}, exp_mem[t], dmem[RESULT_IDX]);
    check({test_name[t], " ebreak"}, {31'd0, exp_ebreak[t]}, {31'd0, ebreak});
    check({test_name[t], " trap"}, {31'd0, exp_trap[t]}, {31'd0, trap});
  endtask

  initial begin
    build_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("NO ERRORS");
    $finish;
  end

  // Hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: core did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: flist.f
design/rv_isa_pkg.sv
design/rv_uarch_pkg.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_lsu.sv
design/rv_core.sv
dv/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rv_core_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
